/* flist.f */
verilog/eth_bus_pkg.sv
verilog/frame_buffer_pkg.sv
verilog/frame_length_fifo.sv
verilog/packet_data_fifo.sv
verilog/rx_frame_admit.sv
verilog/spaced_frame_reader.sv
verilog/eth_crossover_spaced.sv
verification/tb_eth_crossover_spaced.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_eth_crossover_spaced \
	|| { echo "Build failed"; exit 1; }

output=$(./obj_dir/Vtb_eth_crossover_spaced 2>&1)
echo "$output"
echo "$output" | grep -qx "TEST RESULT: PASS" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* verification/tb_eth_crossover_spaced.sv */
`timescale 1ns/1ps

module tb_eth_crossover_spaced
	import eth_bus_pkg::*;
	import frame_buffer_pkg::*;
();

	// Frame counts per phase
	localparam int RANDOM_FRAMES = 24;
	localparam int SHORT_BURST = 14;
	localparam int LONG_BURST = 10;
	localparam int TOTAL_FRAMES = RANDOM_FRAMES + SHORT_BURST + LONG_BURST;
	localparam int RESET_CYCLES = 16;
	localparam int SETTLE_CYCLES = 64;
	// Each frame takes a full spacing slot per word plus header and idle overhead
	// Reset and three drain tails come on top
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (MAX_FRAME_WORDS * WORD_SPACING + 40) +
		RESET_CYCLES + 3 * SETTLE_CYCLES;

	// tx_ready patterns
	localparam int READY_RANDOM = 0;
	localparam int READY_LOW = 1;
	localparam int READY_HIGH = 2;

	logic rx_clk = 1'b0;
	logic arst_n;
	eth_rx_bus_t rx_bus;
	logic tx_ready;
	eth_tx_bus_t tx_bus;

	logic [15:0] lfsr = 16'd11;
	int ready_mode = READY_LOW;
	int timeout_count = 0;

	//////////////////////////////////////////////////
	// Model state updated at the falling edge

	int cycle = 0;
	// Words and headers the DUT still holds
	int used_words = 0;
	int hdr_pending = 0;
	logic frame_kept = 1'b0;
	int cur_len = 0;
	logic [31:0] cur_words[$];
	// Frames expected on tx with the oldest first
	int exp_len[$];
	logic [31:0] exp_words[$];
	// Pops not yet seen by the admit logic
	int rel_cycle[$];
	int rel_words[$];
	logic in_frame = 1'b0;
	int next_valid = 0;
	int idle_from = 0;
	int bytes_left = 0;
	int frame_words = 0;
	// tx_ready one and two cycles back
	logic ready_d1 = 1'b0;
	logic ready_d2 = 1'b0;

	eth_crossover_spaced dut0 (
		.rx_clk(rx_clk), .arst_n(arst_n), .rx_bus(rx_bus), .tx_ready(tx_ready),
		.tx_bus(tx_bus)
	);

	always #4 rx_clk = ~rx_clk;

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// One LFSR step per bit
	function automatic int rand_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
		return value;
	endfunction

	task automatic stop_with_fail();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			stop_with_fail();
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus driven 1 ns after the rising edge

	task automatic next_cycle();
		@(posedge rx_clk);
		#1;
		rx_bus = '0;
		case (ready_mode)
			READY_RANDOM: tx_ready = rand_bits(1) != 0;
			READY_LOW: tx_ready = 1'b0;
			default: tx_ready = 1'b1;
		endcase
	endtask

	task automatic send_frame(input int min_len, input int len_bits, input int gap_bits);
		int remaining;
		int n;
		logic end_in_drop;
		logic [31:0] word;
		remaining = min_len + rand_bits(len_bits);
		end_in_drop = rand_bits(2) == 0;
		next_cycle();
		rx_bus.start = 1'b1;
		while (remaining > 0) begin
			next_cycle();
			n = (remaining > 4) ? 4 : remaining;
			// Unused bytes of a last word stay zero
			word = '0;
			for (int i = 0; i < n; i++)
				word[31 - 8*i -: 8] = 8'(rand_bits(8));
			rx_bus.data_valid = 1'b1;
			rx_bus.data = word;
			rx_bus.bytes_valid = 3'(n);
			remaining -= n;
		end
		next_cycle();
		if (end_in_drop)
			rx_bus.drop = 1'b1;
		else
			rx_bus.commit = 1'b1;
		repeat (rand_bits(gap_bits)) next_cycle();
	endtask

	task automatic wait_drain();
		// Let the model take in the last commit first
		next_cycle();
		while (exp_len.size() != 0 || in_frame)
			next_cycle();
		// Quiet tail where no late frame may show up
		repeat (SETTLE_CYCLES) next_cycle();
	endtask

	initial begin
		arst_n = 1'b0;
		rx_bus = '0;
		tx_ready = 1'b0;
		repeat (RESET_CYCLES) @(posedge rx_clk);
		#1;
		arst_n = 1'b1;

		// Mixed traffic with MAC ready toggling
		ready_mode = READY_RANDOM;
		repeat (RANDOM_FRAMES) send_frame(1, 6, 4);
		wait_drain();

		// Short frames with the MAC stalled hit the header limit
		ready_mode = READY_LOW;
		repeat (SHORT_BURST) send_frame(1, 4, 1);
		ready_mode = READY_HIGH;
		wait_drain();

		// Long frames with the MAC stalled hit the word limit
		ready_mode = READY_LOW;
		repeat (LONG_BURST) send_frame(33, 5, 1);
		ready_mode = READY_HIGH;
		wait_drain();

		$display("TEST RESULT: PASS");
		$finish;
	end

	//////////////////////////////////////////////////
	// Output checks and admission model

	always @(negedge rx_clk) begin
		logic expect_valid;
		int exp_bytes;
		expect_valid = in_frame && (cycle == next_valid);
		check_value("tx data_valid", 32'(expect_valid), 32'(tx_bus.data_valid));

		// Start only from IDLE with a frame pending
		if (!arst_n || in_frame || cycle <= idle_from) begin
			check_value("tx start", 32'd0, 32'(tx_bus.start));
		end else if (tx_bus.start) begin
			if (exp_len.size() == 0) begin
				$display("A frame came out on tx although no committed frame was pending");
				stop_with_fail();
			end else begin
				check_value("tx_ready before start", 32'd1, 32'(ready_d2));
				bytes_left = exp_len.pop_front();
				frame_words = (bytes_left + 3) / 4;
				in_frame = 1'b1;
				next_valid = cycle + 2;
				// Header slot is free from this cycle on
				hdr_pending--;
			end
		end

		if (expect_valid) begin
			exp_bytes = (bytes_left > 4) ? 4 : bytes_left;
			check_value("tx data", exp_words.pop_front(), tx_bus.data);
			check_value("tx bytes_valid", 32'(exp_bytes), 32'(tx_bus.bytes_valid));
			bytes_left -= exp_bytes;
			if (bytes_left == 0) begin
				in_frame = 1'b0;
				// Pop lands one slot after the last word
				idle_from = cycle + WORD_SPACING;
				rel_cycle.push_back(cycle + WORD_SPACING);
				rel_words.push_back(frame_words);
			end else begin
				next_valid = cycle + WORD_SPACING;
			end
		end

		while (rel_cycle.size() != 0 && rel_cycle[0] <= cycle) begin
			used_words -= rel_words.pop_front();
			void'(rel_cycle.pop_front());
		end
		// Keep a frame only with room for a largest frame and a header
		if (rx_bus.start) begin
			frame_kept = (DATA_DEPTH - used_words >= MAX_FRAME_WORDS) &&
				(hdr_pending < HEADER_DEPTH);
			cur_len = 0;
			cur_words.delete();
		end
		if (rx_bus.data_valid && frame_kept) begin
			cur_len += int'(rx_bus.bytes_valid);
			cur_words.push_back(rx_bus.data);
		end
		if (rx_bus.commit && frame_kept) begin
			exp_len.push_back(cur_len);
			foreach (cur_words[i])
				exp_words.push_back(cur_words[i]);
			used_words += cur_words.size();
			hdr_pending++;
		end

		ready_d2 = ready_d1;
		ready_d1 = tx_ready;
		cycle++;
	end

	always @(posedge rx_clk) begin
		timeout_count++;
		if (timeout_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, %0d frames were never sent on tx",
				timeout_count, exp_len.size());
			stop_with_fail();
		end
	end

endmodule

/* verilog/eth_crossover_spaced.sv */
`timescale 1ns/1ps

module eth_crossover_spaced
	import eth_bus_pkg::*;
	import frame_buffer_pkg::*;
(
	input  logic		rx_clk,
	input  logic		arst_n,
	input  eth_rx_bus_t	rx_bus,
	input  logic		tx_ready,
	output eth_tx_bus_t	tx_bus
);

	//////////////////////////////////////////////////
	// Write side

	logic data_wr_en;
	logic data_commit;
	logic data_rollback;
	logic [DATA_PTR_W-1:0] data_free_words;
	logic hdr_wr_en;
	logic hdr_full;
	frame_len_u hdr_wr_len;

	//////////////////////////////////////////////////
	// Read side

	logic hdr_rd_en;
	logic hdr_empty;
	frame_len_u hdr_rd_len;
	logic data_rd_en;
	logic [DATA_PTR_W-1:0] data_rd_offset;
	logic [31:0] data_rd_data;
	logic data_pop_en;
	logic [DATA_PTR_W-1:0] data_pop_words;

	// Drop decision and length count
	rx_frame_admit admit0 (
		.rx_clk(rx_clk), .arst_n(arst_n), .rx_bus(rx_bus),
		.data_free_words(data_free_words), .hdr_full(hdr_full),
		.data_wr_en(data_wr_en), .data_commit(data_commit),
		.data_rollback(data_rollback), .hdr_wr_en(hdr_wr_en), .hdr_wr_len(hdr_wr_len)
	);

	// One length per stored frame
	frame_length_fifo hdr_fifo0 (
		.rx_clk(rx_clk), .arst_n(arst_n), .wr_en(hdr_wr_en), .wr_len(hdr_wr_len),
		.full(hdr_full), .rd_en(hdr_rd_en), .rd_len(hdr_rd_len), .empty(hdr_empty)
	);

	// Frame words with commit and rollback
	packet_data_fifo data_fifo0 (
		.rx_clk(rx_clk), .arst_n(arst_n), .wr_en(data_wr_en), .wr_data(rx_bus.data),
		.commit(data_commit), .rollback(data_rollback), .free_words(data_free_words),
		.rd_en(data_rd_en), .rd_offset(data_rd_offset), .rd_data(data_rd_data),
		.pop_en(data_pop_en), .pop_words(data_pop_words)
	);

	// Replays frames one word per spacing slot
	spaced_frame_reader reader0 (
		.rx_clk(rx_clk), .arst_n(arst_n), .tx_ready(tx_ready),
		.hdr_empty(hdr_empty), .hdr_rd_len(hdr_rd_len), .hdr_rd_en(hdr_rd_en),
		.data_rd_en(data_rd_en), .data_rd_offset(data_rd_offset),
		.data_rd_data(data_rd_data), .data_pop_en(data_pop_en),
		.data_pop_words(data_pop_words), .tx_bus(tx_bus)
	);

endmodule

/* verilog/spaced_frame_reader.sv */
`timescale 1ns/1ps

module spaced_frame_reader
	import eth_bus_pkg::*;
	import frame_buffer_pkg::*;
(
	input  logic			rx_clk,
	input  logic			arst_n,
	input  logic			tx_ready,
	input  logic			hdr_empty,
	input  frame_len_u		hdr_rd_len,
	output logic			hdr_rd_en,
	output logic			data_rd_en,
	output logic [DATA_PTR_W-1:0]	data_rd_offset,
	input  logic [31:0]		data_rd_data,
	output logic			data_pop_en,
	output logic [DATA_PTR_W-1:0]	data_pop_words,
	output eth_tx_bus_t		tx_bus
);

	typedef enum logic [2:0] {
		IDLE,
		HEADER_WAIT,
		DATA_WAIT,
		DATA_FIRST,
		DATA_COUNT
	} state_t;

	state_t state;

	// Spacing counter wraps once per output word
	logic [3:0] count;
	logic [LEN_W-1:0] bytes_read;
	logic [LEN_W-1:0] bytes_left;
	logic last_word;

	// Output bus registers
	logic tx_start;
	logic tx_valid;
	logic [2:0] tx_bytes;
	logic [31:0] tx_data;

	assign bytes_left = hdr_rd_len.bytes - bytes_read;
	// Current word holds the end of the frame
	assign last_word = (bytes_read + LEN_W'(4)) >= hdr_rd_len.bytes;

	//////////////////////////////////////////////////
	// Pop FSM

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			count <= '0;
			bytes_read <= '0;
			hdr_rd_en <= 1'b0;
			data_rd_en <= 1'b0;
			data_rd_offset <= '0;
			data_pop_en <= 1'b0;
			data_pop_words <= '0;
			tx_start <= 1'b0;
			tx_valid <= 1'b0;
			tx_bytes <= '0;
		end else begin
			// Strobes default low
			hdr_rd_en <= 1'b0;
			data_rd_en <= 1'b0;
			data_pop_en <= 1'b0;
			tx_start <= 1'b0;
			tx_valid <= 1'b0;
			tx_bytes <= '0;

			case (state)
				// Ready is looked at only between frames
				IDLE: begin
					if (!hdr_empty && tx_ready) begin
						bytes_read <= '0;
						hdr_rd_en <= 1'b1;
						state <= HEADER_WAIT;
					end
				end
				// A header means the first word is already there
				HEADER_WAIT: begin
					data_rd_en <= 1'b1;
					data_rd_offset <= '0;
					tx_start <= 1'b1;
					state <= DATA_WAIT;
				end
				DATA_WAIT: begin
					count <= '0;
					state <= DATA_FIRST;
				end
				// Word from the FIFO goes out now
				DATA_FIRST: begin
					tx_valid <= 1'b1;
					tx_bytes <= (bytes_left > LEN_W'(4)) ? 3'd4 : bytes_left[2:0];
					count <= count + 1'b1;
					state <= DATA_COUNT;
				end
				// Hold off the slow MAC for the rest of the slot
				DATA_COUNT: begin
					count <= count + 1'b1;
					// Fetch early so the word lands in DATA_FIRST
					if (count == 4'(WORD_SPACING - 2) && !last_word) begin
						data_rd_en <= 1'b1;
						data_rd_offset <= data_rd_offset + 1'b1;
					end
					if (count == 4'(WORD_SPACING - 1)) begin
						if (last_word) begin
							// Partial last word still takes a row
							data_pop_en <= 1'b1;
							data_pop_words <= DATA_PTR_W'(hdr_rd_len.split.words +
								9'(|hdr_rd_len.split.tail));
							state <= IDLE;
						end else begin
							bytes_read <= bytes_read + LEN_W'(4);
							state <= DATA_FIRST;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data word latched as it leaves the FIFO
	always_ff @(posedge rx_clk) begin
		if (state == DATA_FIRST)
			tx_data <= data_rd_data;
	end

	assign tx_bus = '{start: tx_start, data_valid: tx_valid, data: tx_data,
		bytes_valid: tx_bytes};

	// Header length and read offsets must agree with what was written
	assert property (@(posedge rx_clk) disable iff (!arst_n)
		tx_bus.data_valid |-> tx_bus.bytes_valid inside {[3'd1:3'd4]});

endmodule

/* verilog/rx_frame_admit.sv */
`timescale 1ns/1ps

module rx_frame_admit
	import eth_bus_pkg::*;
	import frame_buffer_pkg::*;
(
	input  logic			rx_clk,
	input  logic			arst_n,
	input  eth_rx_bus_t		rx_bus,
	input  logic [DATA_PTR_W-1:0]	data_free_words,
	input  logic			hdr_full,
	output logic			data_wr_en,
	output logic			data_commit,
	output logic			data_rollback,
	output logic			hdr_wr_en,
	output frame_len_u		hdr_wr_len
);

	// Set for a frame that is discarded whole
	logic dropping;
	// Bytes written so far in this frame
	logic [LEN_W-1:0] frame_bytes;

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			dropping <= 1'b0;
			frame_bytes <= '0;
		end else if (rx_bus.start) begin
			frame_bytes <= '0;
			// Keep only if a largest frame and its header both fit
			dropping <= (data_free_words < DATA_PTR_W'(MAX_FRAME_WORDS)) || hdr_full;
		end else if (data_wr_en) begin
			frame_bytes <= frame_bytes + LEN_W'(rx_bus.bytes_valid);
		end
	end

	assign data_wr_en = rx_bus.data_valid && !dropping;
	assign data_commit = rx_bus.commit && !dropping;
	assign data_rollback = rx_bus.drop && !dropping;

	// Header goes in with the commit
	assign hdr_wr_en = data_commit;
	// Count includes a last word arriving with the commit
	assign hdr_wr_len.bytes = frame_bytes +
		(data_wr_en ? LEN_W'(rx_bus.bytes_valid) : LEN_W'(0));

	// All earlier words are full, so bytes bound the word count
	assert property (@(posedge rx_clk) disable iff (!arst_n)
		data_wr_en |-> frame_bytes < LEN_W'(MAX_FRAME_WORDS * 4));

endmodule

/* verilog/packet_data_fifo.sv */
`timescale 1ns/1ps

module packet_data_fifo
	import frame_buffer_pkg::*;
(
	input  logic			rx_clk,
	input  logic			arst_n,
	input  logic			wr_en,
	input  logic [31:0]		wr_data,
	input  logic			commit,
	input  logic			rollback,
	output logic [DATA_PTR_W-1:0]	free_words,
	input  logic			rd_en,
	input  logic [DATA_PTR_W-1:0]	rd_offset,
	output logic [31:0]		rd_data,
	input  logic			pop_en,
	input  logic [DATA_PTR_W-1:0]	pop_words
);

	logic [31:0] mem [DATA_DEPTH];

	//////////////////////////////////////////////////
	// Pointers

	// Speculative write position that moves on every word
	logic [DATA_PTR_W-1:0] wr_ptr;
	// End of the last good frame
	logic [DATA_PTR_W-1:0] commit_ptr;
	// Start of the oldest frame not yet sent
	logic [DATA_PTR_W-1:0] rd_ptr;

	// Write pointer after this cycle's word
	logic [DATA_PTR_W-1:0] wr_ptr_next;
	// Read address for offset reads
	logic [DATA_PTR_W-1:0] rd_addr;

	assign wr_ptr_next = wr_en ? wr_ptr + 1'b1 : wr_ptr;
	assign rd_addr = rd_ptr + rd_offset;

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Rollback throws away the frame in progress
			if (rollback)
				wr_ptr <= commit_ptr;
			else
				wr_ptr <= wr_ptr_next;

			// Last word may arrive with the commit
			if (commit)
				commit_ptr <= wr_ptr_next;

			// Whole frame leaves at once
			if (pop_en)
				rd_ptr <= rd_ptr + pop_words;
		end
	end

	//////////////////////////////////////////////////
	// Storage

	always_ff @(posedge rx_clk) begin
		if (wr_en)
			mem[wr_ptr[DATA_PTR_W-2:0]] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr[DATA_PTR_W-2:0]];
	end

	// Space counts words of the frame still being written
	assign free_words = DATA_PTR_W'(DATA_DEPTH) - (wr_ptr - rd_ptr);

	// Admission threshold must keep any kept frame inside the buffer
	assert property (@(posedge rx_clk) disable iff (!arst_n)
		wr_en |-> free_words != '0);

	// Reader frees only words that were committed
	assert property (@(posedge rx_clk) disable iff (!arst_n)
		pop_en |-> (commit_ptr - rd_ptr) >= pop_words);

endmodule

/* verilog/frame_length_fifo.sv */
`timescale 1ns/1ps

module frame_length_fifo
	import frame_buffer_pkg::*;
(
	input  logic		rx_clk,
	input  logic		arst_n,
	input  logic		wr_en,
	input  frame_len_u	wr_len,
	output logic		full,
	input  logic		rd_en,
	output frame_len_u	rd_len,
	output logic		empty
);

	// One entry per committed frame
	frame_len_u mem [HEADER_DEPTH];

	// Top bit of each pointer is the wrap flag
	logic [HDR_PTR_W-1:0] wr_ptr;
	logic [HDR_PTR_W-1:0] rd_ptr;

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage and output register
	// Output holds its value until the next pop
	always_ff @(posedge rx_clk) begin
		if (wr_en)
			mem[wr_ptr[HDR_PTR_W-2:0]] <= wr_len;
		if (rd_en)
			rd_len <= mem[rd_ptr[HDR_PTR_W-2:0]];
	end

	assign empty = (wr_ptr == rd_ptr);
	// Same address with opposite wrap
	assign full = (wr_ptr[HDR_PTR_W-1] != rd_ptr[HDR_PTR_W-1]) &&
		(wr_ptr[HDR_PTR_W-2:0] == rd_ptr[HDR_PTR_W-2:0]);

	// Admit logic checks full only at frame start
	assert property (@(posedge rx_clk) disable iff (!arst_n) wr_en |-> !full);
	// Reader pops only after seeing a header
	assert property (@(posedge rx_clk) disable iff (!arst_n) rd_en |-> !empty);

endmodule

/* verilog/frame_buffer_pkg.sv */
package frame_buffer_pkg;

	//////////////////////////////////////////////////
	// Buffer sizes

	// Data FIFO rows of one 32-bit word each
	localparam int DATA_DEPTH = 64;
	// Pointer carries one wrap bit above the address
	localparam int DATA_PTR_W = $clog2(DATA_DEPTH) + 1;

	// One header FIFO entry per stored frame
	localparam int HEADER_DEPTH = 8;
	localparam int HDR_PTR_W = $clog2(HEADER_DEPTH) + 1;

	// Largest frame in words
	// Admission needs this much room before a frame starts
	localparam int MAX_FRAME_WORDS = 16;

	// Clock cycles from one output word to the next
	localparam int WORD_SPACING = 16;

	//////////////////////////////////////////////////
	// Frame length as stored in the header FIFO

	localparam int LEN_W = 11;

	typedef union packed {
		// Plain byte count
		logic [LEN_W-1:0]	bytes;
		// Same count split into whole words and leftover bytes
		struct packed {
			logic [8:0]	words;
			logic [1:0]	tail;
		} split;
	} frame_len_u;

endpackage

/* verilog/eth_bus_pkg.sv */
package eth_bus_pkg;

	//////////////////////////////////////////////////
	// Receive side as the fast MAC presents it

	// A frame is start, then data words, then commit or drop
	typedef struct packed {
		// Strobe one cycle ahead of the first word
		logic		start;
		logic		data_valid;
		// First byte on the wire sits in bits 31:24
		logic [31:0]	data;
		// Valid bytes in this word, counted from the top
		logic [2:0]	bytes_valid;
		// End of a good frame
		logic		commit;
		// End of a bad frame whose words are discarded
		logic		drop;
	} eth_rx_bus_t;

	//////////////////////////////////////////////////
	// Transmit side toward the slower MAC

	typedef struct packed {
		logic		start;
		logic		data_valid;
		logic [31:0]	data;
		logic [2:0]	bytes_valid;
	} eth_tx_bus_t;

endpackage
